//--- rtl/edge_eval.sv
`timescale 1ns/1ps
`default_nettype none

module edge_eval (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   freeze,
  input  logic                   scan_valid,
  input  fb_pkg::hcount_t        scan_h,
  input  fb_pkg::vcount_t        scan_v,
  input  logic                   scan_last,
  input  raster_geom_pkg::edge_t ex0,
  input  raster_geom_pkg::edge_t ex1,
  input  raster_geom_pkg::edge_t ex2,
  input  raster_geom_pkg::edge_t ey0,
  input  raster_geom_pkg::edge_t ey1,
  input  raster_geom_pkg::edge_t ey2,
  input  raster_geom_pkg::edge_t ec0,
  input  raster_geom_pkg::edge_t ec1,
  input  raster_geom_pkg::edge_t ec2,
  output logic                   cov_valid,
  output logic                   cov_inside,
  output fb_pkg::hcount_t        cov_h,
  output fb_pkg::vcount_t        cov_v,
  output logic                   cov_last
);
  import raster_geom_pkg::*;
  import fb_pkg::*;

  localparam int POS_W = HCOUNT_W + VCOUNT_W + 2;

  typedef logic [POS_W-1:0] pos_t;  // {valid, last, v, h}

  pos_t  pos_in;
  pos_t  pos_out;
  edge_t ex [3];
  edge_t ey [3];
  edge_t ec [3];
  edge_t px [3];  // stage one, x products
  edge_t py [3];  // stage one, y products
  edge_t e  [3];
  logic  inside_c;

  assign ex = '{ex0, ex1, ex2};
  assign ey = '{ey0, ey1, ey2};
  assign ec = '{ec0, ec1, ec2};

  // the position rides alongside the two arithmetic stages
  assign pos_in = {scan_valid, scan_last, scan_v, scan_h};

  freeze_pipe #(
    .STAGES   (2),
    .payload_t(pos_t)
  ) i_pos_pipe (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .freeze  (freeze),
    .data    (pos_in),
    .data_out(pos_out)
  );

  assign {cov_valid, cov_last, cov_v, cov_h} = pos_out;

  always_ff @(posedge clk_in) begin
    if (!freeze) begin
      for (int i = 0; i < 3; i++) begin
        px[i] <= ex[i] * edge_t'(scan_h);
        py[i] <= ey[i] * edge_t'(scan_v);
      end
    end
  end

  // wraparound in the sum is harmless, the true edge value fits in EDGE_W
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      e[i] = px[i] + py[i] + ec[i];
    end
    inside_c = (e[0] >= 0) && (e[1] >= 0) && (e[2] >= 0);  // edges inclusive
  end

  always_ff @(posedge clk_in) begin
    if (!freeze) begin
      cov_inside <= inside_c;
    end
  end

endmodule

`default_nettype wire

//--- rtl/fb_pkg.sv
`default_nettype none

package fb_pkg;

  // largest framebuffer the counters and address are sized for
  localparam int HRES_MAX = 640;
  localparam int VRES_MAX = 480;

  localparam int HCOUNT_W = $clog2(HRES_MAX);             // 10
  localparam int VCOUNT_W = $clog2(VRES_MAX);             // 9
  localparam int ADDR_W   = $clog2(HRES_MAX * VRES_MAX);  // 19

  typedef logic [HCOUNT_W-1:0] hcount_t;
  typedef logic [VCOUNT_W-1:0] vcount_t;
  typedef logic [ADDR_W-1:0]   addr_t;

endpackage

`default_nettype wire

//--- rtl/frag_out.sv
`timescale 1ns/1ps
`default_nettype none

module frag_out #(
  parameter int FB_HRES = 320,
  parameter int FB_VRES = 180
) (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    cov_valid,
  input  logic                    cov_inside,
  input  fb_pkg::hcount_t         cov_h,
  input  fb_pkg::vcount_t         cov_v,
  input  logic                    cov_last,
  input  raster_geom_pkg::depth_t z_flat,
  input  logic                    cull,
  input  logic                    ready_in,
  output logic                    valid_out,
  output fb_pkg::hcount_t         hcount_out,
  output fb_pkg::vcount_t         vcount_out,
  output raster_geom_pkg::depth_t z_out,
  output fb_pkg::addr_t           addr_out,
  output logic                    done_out,
  output logic                    tri_end,
  output logic                    freeze
);
  import fb_pkg::*;

  localparam addr_t HRES_A = addr_t'(FB_HRES);

  addr_t addr_c;
  logic  last_r;  // output register holds the final scan position

  // a fragment waiting on the consumer stalls the whole pipeline
  assign freeze  = valid_out && !ready_in;
  assign tri_end = done_out;

  always_comb begin
    addr_c = addr_t'(cov_v) * HRES_A + addr_t'(cov_h);  // row major
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_out <= 1'b0;
      last_r    <= 1'b0;
      done_out  <= 1'b0;
    end else begin
      // done once the last position has left whether covered or not
      done_out <= cull || (last_r && !freeze);
      if (!freeze) begin
        valid_out <= cov_valid && cov_inside;  // misses become bubbles
        last_r    <= cov_valid && cov_last;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!freeze) begin
      hcount_out <= cov_h;
      vcount_out <= cov_v;
      z_out      <= z_flat;
      addr_out   <= addr_c;
    end
  end

endmodule

`default_nettype wire

//--- rtl/freeze_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module freeze_pipe #(
  parameter int  STAGES    = 2,
  parameter type payload_t = logic
) (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     freeze,
  input  payload_t data,
  output payload_t data_out
);

  payload_t stage_q [STAGES];

  // whole line stalls together so nothing inside is dropped or doubled
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_q[i] <= '0;  // valid bits in the payload start low
      end
    end else if (!freeze) begin
      stage_q[0] <= data;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_out = stage_q[STAGES-1];

endmodule

`default_nettype wire

//--- rtl/raster_geom_pkg.sv
`default_nettype none

package raster_geom_pkg;

  // vertex coordinates are whole pixels
  localparam int COORD_W = 10;
  typedef logic [COORD_W-1:0] coord_t;

  localparam int DEPTH_W = 16;
  typedef logic [DEPTH_W-1:0] depth_t;

  // cross product of two coordinate differences plus sign and headroom
  localparam int EDGE_W = 2 * COORD_W + 2;
  typedef logic signed [EDGE_W-1:0] edge_t;  // edge values and doubled area

endpackage

`default_nettype wire

//--- rtl/scan_gen.sv
`timescale 1ns/1ps
`default_nettype none

module scan_gen #(
  parameter int FB_HRES = 320,
  parameter int FB_VRES = 180
) (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            freeze,
  input  logic            start,
  input  fb_pkg::hcount_t hmin,
  input  fb_pkg::hcount_t hmax,
  input  fb_pkg::vcount_t vmin,
  input  fb_pkg::vcount_t vmax,
  output logic            scan_valid,
  output fb_pkg::hcount_t scan_h,
  output fb_pkg::vcount_t scan_v,
  output logic            scan_last
);
  import fb_pkg::*;

  hcount_t next_h;
  vcount_t next_v;
  logic    first_last;
  logic    next_last;
  logic    step;

  assign first_last = (hmin == hmax) && (vmin == vmax);  // one pixel box
  assign step       = scan_valid && !freeze;

  always_comb begin
    if (scan_h == hmax) begin
      next_h = hmin;  // wrap to the left edge of the box
      next_v = scan_v + 1'b1;
    end else begin
      next_h = scan_h + 1'b1;
      next_v = scan_v;
    end
    next_last = (next_h == hmax) && (next_v == vmax);
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      scan_valid <= 1'b0;
      scan_last  <= 1'b0;
    end else if (start) begin
      scan_valid <= 1'b1;
      scan_last  <= first_last;
    end else if (step) begin
      scan_valid <= !scan_last;  // stop once (hmax, vmax) has gone out
      scan_last  <= !scan_last && next_last;
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      scan_h <= hmin;
      scan_v <= vmin;
    end else if (step && !scan_last) begin
      scan_h <= next_h;
      scan_v <= next_v;
    end
  end

endmodule

`default_nettype wire

//--- rtl/tri_raster_top.sv
`timescale 1ns/1ps
`default_nettype none

module tri_raster_top #(
  parameter int FB_HRES = 320,
  parameter int FB_VRES = 180
) (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    valid_in,
  output logic                    ready_out,
  input  raster_geom_pkg::coord_t x0,
  input  raster_geom_pkg::coord_t x1,
  input  raster_geom_pkg::coord_t x2,
  input  raster_geom_pkg::coord_t y0,
  input  raster_geom_pkg::coord_t y1,
  input  raster_geom_pkg::coord_t y2,
  input  raster_geom_pkg::depth_t z0,
  output logic                    valid_out,
  input  logic                    ready_in,
  output fb_pkg::hcount_t         hcount_out,
  output fb_pkg::vcount_t         vcount_out,
  output raster_geom_pkg::depth_t z_out,
  output fb_pkg::addr_t           addr_out,
  output logic                    done_out
);
  import raster_geom_pkg::*;
  import fb_pkg::*;

  logic    start, cull, tri_end, freeze;
  hcount_t hmin, hmax;
  vcount_t vmin, vmax;
  edge_t   ex0, ex1, ex2, ey0, ey1, ey2, ec0, ec1, ec2;
  depth_t  z_flat;
  logic    scan_valid, scan_last;
  hcount_t scan_h;
  vcount_t scan_v;
  logic    cov_valid, cov_inside, cov_last;
  hcount_t cov_h;
  vcount_t cov_v;

  tri_setup #(.FB_HRES(FB_HRES), .FB_VRES(FB_VRES)) i_setup (
    .clk_in(clk_in), .rst_in(rst_in), .valid_in(valid_in), .ready_out(ready_out),
    .x0(x0), .x1(x1), .x2(x2), .y0(y0), .y1(y1), .y2(y2), .z0(z0),
    .tri_end(tri_end), .start(start), .cull(cull),
    .hmin(hmin), .hmax(hmax), .vmin(vmin), .vmax(vmax),
    .ex0(ex0), .ex1(ex1), .ex2(ex2), .ey0(ey0), .ey1(ey1), .ey2(ey2),
    .ec0(ec0), .ec1(ec1), .ec2(ec2), .z_flat(z_flat)
  );

  scan_gen #(.FB_HRES(FB_HRES), .FB_VRES(FB_VRES)) i_scan (
    .clk_in(clk_in), .rst_in(rst_in), .freeze(freeze), .start(start),
    .hmin(hmin), .hmax(hmax), .vmin(vmin), .vmax(vmax),
    .scan_valid(scan_valid), .scan_h(scan_h), .scan_v(scan_v), .scan_last(scan_last)
  );

  edge_eval i_edge (
    .clk_in(clk_in), .rst_in(rst_in), .freeze(freeze),
    .scan_valid(scan_valid), .scan_h(scan_h), .scan_v(scan_v), .scan_last(scan_last),
    .ex0(ex0), .ex1(ex1), .ex2(ex2), .ey0(ey0), .ey1(ey1), .ey2(ey2),
    .ec0(ec0), .ec1(ec1), .ec2(ec2),
    .cov_valid(cov_valid), .cov_inside(cov_inside),
    .cov_h(cov_h), .cov_v(cov_v), .cov_last(cov_last)
  );

  // cull goes straight to the output stage for its done pulse
  frag_out #(.FB_HRES(FB_HRES), .FB_VRES(FB_VRES)) i_frag (
    .clk_in(clk_in), .rst_in(rst_in),
    .cov_valid(cov_valid), .cov_inside(cov_inside),
    .cov_h(cov_h), .cov_v(cov_v), .cov_last(cov_last),
    .z_flat(z_flat), .cull(cull), .ready_in(ready_in),
    .valid_out(valid_out), .hcount_out(hcount_out), .vcount_out(vcount_out),
    .z_out(z_out), .addr_out(addr_out),
    .done_out(done_out), .tri_end(tri_end), .freeze(freeze)
  );

endmodule

`default_nettype wire

//--- rtl/tri_setup.sv
`timescale 1ns/1ps
`default_nettype none

module tri_setup #(
  parameter int FB_HRES = 320,
  parameter int FB_VRES = 180
) (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    valid_in,
  output logic                    ready_out,
  input  raster_geom_pkg::coord_t x0,
  input  raster_geom_pkg::coord_t x1,
  input  raster_geom_pkg::coord_t x2,
  input  raster_geom_pkg::coord_t y0,
  input  raster_geom_pkg::coord_t y1,
  input  raster_geom_pkg::coord_t y2,
  input  raster_geom_pkg::depth_t z0,
  input  logic                    tri_end,
  output logic                    start,
  output logic                    cull,
  output fb_pkg::hcount_t         hmin,
  output fb_pkg::hcount_t         hmax,
  output fb_pkg::vcount_t         vmin,
  output fb_pkg::vcount_t         vmax,
  output raster_geom_pkg::edge_t  ex0,
  output raster_geom_pkg::edge_t  ex1,
  output raster_geom_pkg::edge_t  ex2,
  output raster_geom_pkg::edge_t  ey0,
  output raster_geom_pkg::edge_t  ey1,
  output raster_geom_pkg::edge_t  ey2,
  output raster_geom_pkg::edge_t  ec0,
  output raster_geom_pkg::edge_t  ec1,
  output raster_geom_pkg::edge_t  ec2,
  output raster_geom_pkg::depth_t z_flat
);
  import raster_geom_pkg::*;
  import fb_pkg::*;

  localparam coord_t H_LAST = coord_t'(FB_HRES - 1);
  localparam coord_t V_LAST = coord_t'(FB_VRES - 1);

  typedef enum logic [2:0] {S_IDLE, S_CAPTURE, S_BOX, S_AREA, S_BUSY} state_t;

  state_t state;
  coord_t xv [3];
  coord_t yv [3];
  coord_t x_lo, x_hi, y_lo, y_hi;
  edge_t  dx [3];  // b - a along edge a->b
  edge_t  dy [3];
  edge_t  ex_r [3];
  edge_t  ey_r [3];
  edge_t  ec_r [3];
  edge_t  ex_o [3];
  edge_t  ey_o [3];
  edge_t  ec_o [3];
  edge_t  area;
  logic   neg;

  assign ready_out = (state == S_IDLE);
  assign neg       = (area < 0);  // clockwise, flip so inside is always >= 0
  assign start     = (state == S_AREA) && (area != 0);
  assign cull      = (state == S_AREA) && (area == 0);

  always_comb begin
    x_lo = xv[0];
    x_hi = xv[0];
    y_lo = yv[0];
    y_hi = yv[0];
    for (int i = 1; i < 3; i++) begin
      if (xv[i] < x_lo) x_lo = xv[i];
      if (xv[i] > x_hi) x_hi = xv[i];
      if (yv[i] < y_lo) y_lo = yv[i];
      if (yv[i] > y_hi) y_hi = yv[i];
    end
    for (int i = 0; i < 3; i++) begin
      ex_o[i] = neg ? -ex_r[i] : ex_r[i];
      ey_o[i] = neg ? -ey_r[i] : ey_r[i];
      ec_o[i] = neg ? -ec_r[i] : ec_r[i];
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:    if (valid_in) state <= S_CAPTURE;
        S_CAPTURE: state <= S_BOX;
        S_BOX:     state <= S_AREA;
        S_AREA:    state <= (area == 0) ? S_IDLE : S_BUSY;  // zero area is culled
        S_BUSY:    if (tri_end) state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (ready_out && valid_in) begin
      xv     <= '{x0, x1, x2};
      yv     <= '{y0, y1, y2};
      z_flat <= z0;  // flat depth from the provoking vertex
    end
    if (state == S_CAPTURE) begin
      hmin <= hcount_t'((x_lo > H_LAST) ? H_LAST : x_lo);
      hmax <= hcount_t'((x_hi > H_LAST) ? H_LAST : x_hi);
      vmin <= vcount_t'((y_lo > V_LAST) ? V_LAST : y_lo);
      vmax <= vcount_t'((y_hi > V_LAST) ? V_LAST : y_hi);
      for (int i = 0; i < 3; i++) begin
        dx[i] <= edge_t'(xv[(i+1)%3]) - edge_t'(xv[i]);
        dy[i] <= edge_t'(yv[(i+1)%3]) - edge_t'(yv[i]);
      end
    end
    if (state == S_BOX) begin
      // E(x,y) = dy*x - dx*y + (ya*dx - xa*dy)
      for (int i = 0; i < 3; i++) begin
        ex_r[i] <= dy[i];
        ey_r[i] <= -dx[i];
        ec_r[i] <= edge_t'(yv[i]) * dx[i] - edge_t'(xv[i]) * dy[i];
      end
      area <= dx[0] * dy[2] - dx[2] * dy[0];  // edge 0->1 taken at vertex 2
    end
  end

  assign ex0 = ex_o[0];
  assign ex1 = ex_o[1];
  assign ex2 = ex_o[2];
  assign ey0 = ey_o[0];
  assign ey1 = ey_o[1];
  assign ey2 = ey_o[2];
  assign ec0 = ec_o[0];
  assign ec1 = ec_o[1];
  assign ec2 = ec_o[2];

endmodule

`default_nettype wire

//--- tri_raster.f
+incdir+verification
rtl/raster_geom_pkg.sv
rtl/fb_pkg.sv
rtl/freeze_pipe.sv
rtl/tri_setup.sv
rtl/scan_gen.sv
rtl/edge_eval.sv
rtl/frag_out.sv
rtl/tri_raster_top.sv
verification/tri_raster_tb.sv

//--- verification/tri_raster_model.svh
`ifndef TRI_RASTER_MODEL_SVH
`define TRI_RASTER_MODEL_SVH

// bounding box of the three vertices, each bound clamped to the last column or row
function automatic void clamp_box(input int xa, input int xb, input int xc,
                                  input int ya, input int yb, input int yc,
                                  input int hres, input int vres,
                                  output int h_lo, output int h_hi,
                                  output int v_lo, output int v_hi);
  h_lo = (xa < xb) ? ((xa < xc) ? xa : xc) : ((xb < xc) ? xb : xc);
  h_hi = (xa > xb) ? ((xa > xc) ? xa : xc) : ((xb > xc) ? xb : xc);
  v_lo = (ya < yb) ? ((ya < yc) ? ya : yc) : ((yb < yc) ? yb : yc);
  v_hi = (ya > yb) ? ((ya > yc) ? ya : yc) : ((yb > yc) ? yb : yc);
  if (h_lo > hres - 1) h_lo = hres - 1;
  if (h_hi > hres - 1) h_hi = hres - 1;
  if (v_lo > vres - 1) v_lo = vres - 1;
  if (v_hi > vres - 1) v_hi = vres - 1;
endfunction

// pixel is inside when it lies on the inner side of all three edges, edges included
function automatic bit pixel_covered(input int xa, input int ya, input int xb, input int yb,
                                     input int xc, input int yc, input int px, input int py);
  int  area;
  int  c0, c1, c2;
  bit  hit;
  area = (xb - xa) * (yc - ya) - (yb - ya) * (xc - xa);
  c0   = (xb - xa) * (py - ya) - (yb - ya) * (px - xa);
  c1   = (xc - xb) * (py - yb) - (yc - yb) * (px - xb);
  c2   = (xa - xc) * (py - yc) - (ya - yc) * (px - xc);
  hit  = 1'b0;  // zero area covers nothing
  if (area > 0) hit = (c0 >= 0) && (c1 >= 0) && (c2 >= 0);
  if (area < 0) hit = (c0 <= 0) && (c1 <= 0) && (c2 <= 0);  // other winding
  return hit;
endfunction

function automatic int frag_addr(input int h, input int v, input int hres);
  return v * hres + h;  // row major
endfunction

`endif

//--- verification/tri_raster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tri_raster_tb;
  import raster_geom_pkg::*;
  import fb_pkg::*;

  localparam int HRES  = 320;
  localparam int VRES  = 180;
  localparam int NRAND = 53;  // three for the stall test, fifty back to back

  `include "tri_raster_model.svh"

  logic    clk_in, rst_in, valid_in, ready_out, valid_out, ready_in, done_out;
  coord_t  x0, x1, x2, y0, y1, y2;
  depth_t  z0, z_out;
  hcount_t hcount_out;
  vcount_t vcount_out;
  addr_t   addr_out;

  hcount_t exp_h [$];
  vcount_t exp_v [$];
  depth_t  exp_z [$];
  addr_t   exp_a [$];
  int      seed        = 70;
  int      cycle_count = 0;
  int      cycle_limit = 1000;
  int      tri_count   = 0;
  int      done_count  = 0;
  bit      stall_mode  = 1'b0;
  logic    held_valid  = 1'b0;
  hcount_t held_h;
  vcount_t held_v;
  depth_t  held_z;
  addr_t   held_a;
  int      rx [NRAND][3];
  int      ry [NRAND][3];

  tri_raster_top #(.FB_HRES(HRES), .FB_VRES(VRES)) i_dut (.*);

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  function automatic int pick_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic report_mismatch(input string name, input int exp, input int act);
    $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    $display("Result: FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic hcount_check(input string name, input hcount_t exp, input hcount_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic vcount_check(input string name, input vcount_t exp, input vcount_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic depth_check(input string name, input depth_t exp, input depth_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic addr_check(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  // expected fragments of the triangle on the inputs, in raster order
  task automatic expect_triangle();
    int h_lo, h_hi, v_lo, v_hi;
    clamp_box(x0, x1, x2, y0, y1, y2, HRES, VRES, h_lo, h_hi, v_lo, v_hi);
    for (int v = v_lo; v <= v_hi; v++) begin
      for (int h = h_lo; h <= h_hi; h++) begin
        if (pixel_covered(x0, y0, x1, y1, x2, y2, h, v)) begin
          exp_h.push_back(hcount_t'(h));
          exp_v.push_back(vcount_t'(v));
          exp_z.push_back(z0);  // flat depth from vertex 0
          exp_a.push_back(addr_t'(frag_addr(h, v, HRES)));
        end
      end
    end
  endtask

  task automatic send_triangle(input int xa, input int ya, input int xb, input int yb,
                               input int xc, input int yc, input int z);
    int h_lo, h_hi, v_lo, v_hi;
    clamp_box(xa, xb, xc, ya, yb, yc, HRES, VRES, h_lo, h_hi, v_lo, v_hi);
    cycle_limit += 4 * ((h_hi - h_lo + 1) * (v_hi - v_lo + 1) + 10);
    @(negedge clk_in);
    valid_in = 1'b1;
    x0 = coord_t'(xa);
    y0 = coord_t'(ya);
    x1 = coord_t'(xb);
    y1 = coord_t'(yb);
    x2 = coord_t'(xc);
    y2 = coord_t'(yc);
    z0 = depth_t'(z);
    while (!ready_out) @(negedge clk_in);
    @(posedge clk_in);  // taken on this edge
  endtask

  task automatic wait_all_done();
    @(negedge clk_in);
    valid_in = 1'b0;
    while (done_count != tri_count) @(negedge clk_in);
  endtask

  always @(posedge clk_in) begin
    cycle_count++;
    if (cycle_count > cycle_limit) abort_run("timeout, the DUT stopped making progress");
  end

  always @(negedge clk_in) begin
    ready_in = stall_mode ? (pick_below(3) != 0) : 1'b1;  // low about a third of the time
  end

  // scoreboard
  always @(posedge clk_in) begin
    if (!rst_in) begin
      if (held_valid) begin  // stalled last edge, so the fragment must not have moved
        if (!valid_out) abort_run("valid_out dropped while the fragment was stalled");
        hcount_check("hcount_out (stalled)", held_h, hcount_out);
        vcount_check("vcount_out (stalled)", held_v, vcount_out);
        depth_check("z_out (stalled)", held_z, z_out);
        addr_check("addr_out (stalled)", held_a, addr_out);
      end
      held_valid = valid_out && !ready_in;
      held_h     = hcount_out;
      held_v     = vcount_out;
      held_z     = z_out;
      held_a     = addr_out;
      if (valid_out && ready_in) begin
        if (exp_h.size() == 0) begin
          abort_run("the DUT sent a fragment that was not expected");
        end else begin
          hcount_check("hcount_out", exp_h.pop_front(), hcount_out);
          vcount_check("vcount_out", exp_v.pop_front(), vcount_out);
          depth_check("z_out", exp_z.pop_front(), z_out);
          addr_check("addr_out", exp_a.pop_front(), addr_out);
        end
      end
      if (done_out) begin
        if (done_count == tri_count) abort_run("done_out pulsed with no triangle in flight");
        if (exp_h.size() != 0) abort_run("done_out pulsed before all fragments arrived");
        done_count++;
      end
      if (valid_in && ready_out) begin
        expect_triangle();
        tri_count++;
      end
    end
  end

  initial begin
    int cx;
    int cy;
    rst_in   = 1'b1;
    valid_in = 1'b0;
    ready_in = 1'b1;
    x0 = '0;
    x1 = '0;
    x2 = '0;
    y0 = '0;
    y1 = '0;
    y2 = '0;
    z0 = '0;
    // small random triangles, some of them hanging off the screen
    for (int i = 0; i < NRAND; i++) begin
      cx = pick_below(330);
      cy = pick_below(190);
      for (int k = 0; k < 3; k++) begin
        rx[i][k] = cx + pick_below(16);
        ry[i][k] = cy + pick_below(16);
      end
    end
    repeat (5) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;

    send_triangle(10, 10, 20, 12, 14, 20, 16'h1234);
    wait_all_done();
    send_triangle(10, 10, 14, 20, 20, 12, 16'h1234);  // reversed winding
    wait_all_done();
    send_triangle(5, 5, 15, 10, 25, 15, 16'h0042);  // collinear
    wait_all_done();
    if (!ready_out) abort_run("ready_out stayed low after a culled triangle");
    send_triangle(300, 170, 345, 176, 310, 200, 16'h0777);  // past right and bottom edges
    wait_all_done();

    stall_mode = 1'b1;
    send_triangle(10, 10, 20, 12, 14, 20, 16'h1234);
    wait_all_done();
    for (int i = 0; i < 3; i++) begin
      send_triangle(rx[i][0], ry[i][0], rx[i][1], ry[i][1], rx[i][2], ry[i][2], i * 97);
      wait_all_done();
    end
    stall_mode = 1'b0;

    // valid_in stays high between these
    for (int i = 3; i < NRAND; i++) begin
      send_triangle(rx[i][0], ry[i][0], rx[i][1], ry[i][1], rx[i][2], ry[i][2], i * 97);
    end
    wait_all_done();

    if (exp_h.size() != 0 || done_count != tri_count) begin
      $display("ERROR: %0d fragments never arrived", exp_h.size());
      $display("Result: FAILED");
      $fatal(1, "fragments missing at the end");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
